// File: source/keypad_pkg.sv
package keypad_pkg;

    localparam int num_keys = 12;

    // bit order of keypad_in: 1..9, 0, star, hash
    typedef logic [3:0] key_code_t;

    localparam key_code_t key_zero = 4'd9;
    localparam key_code_t key_star = 4'd10;
    localparam key_code_t key_hash = 4'd11;

    typedef enum logic [1:0] {
        key_class_digit,
        key_class_star,
        key_class_hash,
        key_class_none
    } key_class_t;

    function automatic key_class_t classify_key(input key_code_t code);
        key_class_t cls;
        if (code <= key_zero)
            cls = key_class_digit;
        else if (code == key_star)
            cls = key_class_star;
        else if (code == key_hash)
            cls = key_class_hash;
        else
            cls = key_class_none;
        return cls;
    endfunction

    // digit keys only; code 9 is the zero key
    function automatic logic [3:0] key_to_digit(input key_code_t code);
        logic [3:0] value;
        value = (code == key_zero) ? 4'd0 : code + 4'd1;
        return value;
    endfunction

endpackage

// File: source/segment_pkg.sv
package segment_pkg;

    localparam int num_digits = 8;
    localparam int seg_width  = 7;

    // bit 6 is segment a, bit 0 is segment g, active high
    typedef logic [seg_width-1:0] seg_t;

    // digit 0 sits in the lowest bits
    typedef seg_t [num_digits-1:0] frame_t;

    localparam seg_t seg_blank = '0;

    function automatic seg_t seg_pattern(input logic [3:0] value);
        seg_t pattern;
        case (value)
            4'd0:    pattern = 7'b1111110;
            4'd1:    pattern = 7'b0110000;
            4'd2:    pattern = 7'b1101101;
            4'd3:    pattern = 7'b1111001;
            4'd4:    pattern = 7'b0110011;
            4'd5:    pattern = 7'b1011011;
            4'd6:    pattern = 7'b1011111;
            4'd7:    pattern = 7'b1110000;
            4'd8:    pattern = 7'b1111111;
            4'd9:    pattern = 7'b1111011;
            default: pattern = seg_blank; // not a decimal digit
        endcase
        return pattern;
    endfunction

endpackage

// File: source/keypad_scan.sv
module keypad_scan
    import keypad_pkg::*;
#(
    parameter int debounce_cycles = 16
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [num_keys-1:0] keypad_in,
    output logic                key_valid,
    output key_code_t           key_code
);

    localparam int cnt_w = (debounce_cycles > 1) ? $clog2(debounce_cycles) : 1;
    localparam logic [cnt_w-1:0] stable_last = cnt_w'(debounce_cycles - 1);

    logic [num_keys-1:0] sync_0;
    logic [num_keys-1:0] sync_1;
    logic [num_keys-1:0] sample_q;  // last sampled pattern
    logic [num_keys-1:0] accepted;  // debounced pattern
    logic [cnt_w-1:0]    stable_cnt;
    logic                accept;

    function automatic key_code_t encode_key(input logic [num_keys-1:0] pattern);
        key_code_t code;
        code = '0;
        for (int i = 0; i < num_keys; i++) begin
            if (pattern[i])
                code = key_code_t'(i);
        end
        return code;
    endfunction

    // stable long enough and different from what was accepted
    assign accept = (sync_1 == sample_q) && (stable_cnt == stable_last)
                    && (accepted != sample_q);

    always_ff @(posedge clk) begin
        if (rst) begin
            sync_0     <= '0;
            sync_1     <= '0;
            sample_q   <= '0;
            stable_cnt <= '0;
            accepted   <= '0;
            key_valid  <= 1'b0;
        end else begin
            sync_0    <= keypad_in;
            sync_1    <= sync_0;
            key_valid <= 1'b0;
            if (sync_1 != sample_q) begin
                sample_q   <= sync_1;
                stable_cnt <= '0; // restart debounce
            end else if (stable_cnt != stable_last) begin
                stable_cnt <= stable_cnt + 1'b1;
            end
            if (accept) begin
                accepted  <= sample_q;
                key_valid <= (accepted == '0) && $onehot(sample_q); // idle to single key
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept)
            key_code <= encode_key(sample_q);
    end

    assert property (@(posedge clk) disable iff (rst) key_valid |-> (key_code < num_keys));

endmodule

// File: source/digit_entry.sv
module digit_entry
    import keypad_pkg::*;
    import segment_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      key_valid,
    input  key_code_t key_code,
    output frame_t    staged_frame,
    output logic      commit
);

    localparam int cursor_w = $clog2(num_digits);

    logic [cursor_w-1:0] cursor;
    key_class_t          key_class;
    seg_t                key_pattern;

    assign key_class   = classify_key(key_code);
    assign key_pattern = seg_pattern(key_to_digit(key_code));

    always_ff @(posedge clk) begin
        if (rst) begin
            staged_frame <= {num_digits{seg_blank}};
            cursor       <= '0;
            commit       <= 1'b0;
        end else begin
            commit <= 1'b0;
            if (key_valid) begin
                case (key_class)
                    key_class_digit: staged_frame[cursor] <= key_pattern;
                    key_class_hash:  cursor <= cursor + 1'b1; // wraps after last digit
                    key_class_star:  commit <= 1'b1;
                    default:         ;
                endcase
            end
        end
    end

    // a star event lasts one cycle, so commit can never stretch
    assert property (@(posedge clk) disable iff (rst) commit |=> !commit);

endmodule

// File: source/digit_register_file.sv
module digit_register_file
    import segment_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   commit,
    input  frame_t staged_frame,
    output frame_t display_frame
);

    // all digits load together so the panel never shows a partial edit
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int d = 0; d < num_digits; d++)
                display_frame[d] <= seg_blank;
        end else if (commit) begin
            for (int d = 0; d < num_digits; d++)
                display_frame[d] <= staged_frame[d];
        end
    end

endmodule

// File: source/segment_mux.sv
module segment_mux
    import segment_pkg::*;
#(
    parameter int scan_divide = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  frame_t                display_frame,
    output seg_t                  seg_data,
    output logic [num_digits-1:0] digit_sel
);

    localparam int pre_w  = (scan_divide > 1) ? $clog2(scan_divide) : 1;
    localparam int idx_w  = $clog2(num_digits);
    localparam logic [pre_w-1:0] pre_last = pre_w'(scan_divide - 1);

    logic [pre_w-1:0] pre_cnt;
    logic [idx_w-1:0] digit_idx;
    logic [idx_w-1:0] next_idx;
    logic             wrap;

    assign wrap     = (pre_cnt == pre_last);
    assign next_idx = wrap ? digit_idx + 1'b1 : digit_idx;

    always_ff @(posedge clk) begin
        if (rst) begin
            pre_cnt   <= pre_last;  // first edge out of reset wraps
            digit_idx <= idx_w'(num_digits - 1); // so digit 0 comes first
            digit_sel <= '0;
            seg_data  <= seg_blank;
        end else begin
            pre_cnt   <= wrap ? '0 : pre_cnt + 1'b1;
            digit_idx <= next_idx;
            digit_sel <= num_digits'(1) << next_idx;
            seg_data  <= display_frame[next_idx]; // same digit as select
        end
    end

    assert property (@(posedge clk) disable iff (rst) 1'b1 |=> $onehot(digit_sel));

endmodule

// File: source/keypad_display_top.sv
module keypad_display_top
    import keypad_pkg::*;
    import segment_pkg::*;
#(
    parameter int debounce_cycles = 16,
    parameter int scan_divide     = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [num_keys-1:0]   keypad_in,
    output seg_t                  seg_data,
    output logic [num_digits-1:0] digit_sel
);

    logic      key_valid;
    key_code_t key_code;
    logic      commit;
    frame_t    staged_frame;
    frame_t    display_frame;

    keypad_scan #(
        .debounce_cycles(debounce_cycles)
    ) u_keypad_scan (
        .clk      (clk),
        .rst      (rst),
        .keypad_in(keypad_in),
        .key_valid(key_valid),
        .key_code (key_code)
    );

    digit_entry u_digit_entry (
        .clk         (clk),
        .rst         (rst),
        .key_valid   (key_valid),
        .key_code    (key_code),
        .staged_frame(staged_frame),
        .commit      (commit)
    );

    digit_register_file u_digit_register_file (
        .clk          (clk),
        .rst          (rst),
        .commit       (commit),
        .staged_frame (staged_frame),
        .display_frame(display_frame)
    );

    segment_mux #(
        .scan_divide(scan_divide)
    ) u_segment_mux (
        .clk          (clk),
        .rst          (rst),
        .display_frame(display_frame),
        .seg_data     (seg_data),
        .digit_sel    (digit_sel)
    );

endmodule

// File: dv/keypad_display_tb.sv
module keypad_display_tb
    import keypad_pkg::*;
    import segment_pkg::*;
();

    localparam int debounce_cycles = 16;
    localparam int scan_divide     = 4;
    localparam int clk_period      = 40;
    localparam int hold_cycles     = debounce_cycles + 6;
    localparam int settle_cycles   = num_digits * scan_divide + 2;
    localparam int max_presses     = 80;
    localparam int timeout_cycles  = max_presses * (2 * hold_cycles + settle_cycles) + 400;

    logic                  clk;
    logic                  rst;
    logic [num_keys-1:0]   keypad_in;
    seg_t                  seg_data;
    logic [num_digits-1:0] digit_sel;

    // reference model
    seg_t        staging[num_digits];
    seg_t        exp_display[num_digits];
    int          cursor;
    seg_t        expected_seg;
    logic        check_en;
    logic        sel_check_en;
    logic [31:0] rng_state;

    // scan tracking for the rotation check
    logic [num_digits-1:0] prev_sel;
    int                    dwell;
    logic                  dwell_valid;

    int error_count;
    int tests_passed;
    int tests_failed;

    keypad_display_top #(
        .debounce_cycles(debounce_cycles),
        .scan_divide    (scan_divide)
    ) u_keypad_display_top (
        .clk      (clk),
        .rst      (rst),
        .keypad_in(keypad_in),
        .seg_data (seg_data),
        .digit_sel(digit_sel)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always_comb begin
        expected_seg = seg_blank; // no digit selected yet
        for (int d = 0; d < num_digits; d++) begin
            if (digit_sel[d])
                expected_seg = exp_display[d];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prev_sel    <= '0;
            dwell       <= 0;
            dwell_valid <= 1'b0;
        end else begin
            prev_sel <= digit_sel;
            if (digit_sel != prev_sel) begin
                dwell       <= 1;
                dwell_valid <= 1'b1;
            end else begin
                dwell <= dwell + 1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) check_en |-> (seg_data == expected_seg))
    else begin
        error_count++;
        $display("error at %0t: digit_sel %b shows segments %b, expected %b", $time,
                 $sampled(digit_sel), $sampled(seg_data), $sampled(expected_seg));
    end

    assert property (@(posedge clk) disable iff (rst) sel_check_en |-> $onehot(digit_sel))
    else begin
        error_count++;
        $display("error at %0t: digit select %b is not one-hot", $time, $sampled(digit_sel));
    end

    assert property (@(posedge clk) disable iff (rst)
        (dwell_valid && (digit_sel != prev_sel)) |->
            ((digit_sel == {prev_sel[num_digits-2:0], prev_sel[num_digits-1]})
             && (dwell == scan_divide)))
    else begin
        error_count++;
        $display("error at %0t: scan stepped from %b to %b after %0d cycles", $time,
                 $sampled(prev_sel), $sampled(digit_sel), $sampled(dwell));
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // key index to decimal value, zero key sits after nine
    function automatic logic [3:0] digit_value(input int code);
        return (code == 9) ? 4'd0 : 4'(code + 1);
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic drive_keys(input logic [num_keys-1:0] pattern, input int cycles);
        keypad_in = pattern;
        repeat (cycles) @(negedge clk);
    endtask

    task automatic press_key(input int code);
        drive_keys(num_keys'(1) << code, hold_cycles);
    endtask

    task automatic release_key();
        drive_keys('0, hold_cycles);
    endtask

    task automatic enter_key(input int code);
        if (code == int'(key_star))
            check_en = 1'b0; // frame swaps mid-scan
        press_key(code);
        release_key();
        if (code == int'(key_star)) begin
            wait_cycles(settle_cycles);
            for (int d = 0; d < num_digits; d++)
                exp_display[d] = staging[d];
            check_en = 1'b1;
        end else if (code == int'(key_hash)) begin
            cursor = (cursor + 1) % num_digits;
        end else begin
            staging[cursor] = seg_pattern(digit_value(code));
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, error_count - errors_before);
        end
    endtask

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("timeout: run did not finish within %0d clock cycles", timeout_cycles);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        int errors_before;
        int code;
        rst          = 1'b1;
        keypad_in    = '0;
        check_en     = 1'b0;
        sel_check_en = 1'b0;
        cursor       = 0;
        rng_state    = 32'ha3f6f764;
        error_count  = 0;
        tests_passed = 0;
        tests_failed = 0;
        for (int d = 0; d < num_digits; d++) begin
            staging[d]     = seg_blank;
            exp_display[d] = seg_blank;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst      = 1'b0;
        check_en = 1'b1;
        wait_cycles(2);
        sel_check_en = 1'b1;

        errors_before = error_count;
        wait_cycles(2 * num_digits * scan_divide);
        finish_test("reset and scan", errors_before);

        errors_before = error_count;
        enter_key(0);
        enter_key(key_hash);
        enter_key(1);
        enter_key(key_hash);
        enter_key(2);
        enter_key(key_star);
        finish_test("enter and commit", errors_before);

        errors_before = error_count;
        repeat (9) enter_key(key_hash);
        enter_key(6);
        enter_key(key_star);
        finish_test("cursor wrap", errors_before);

        errors_before = error_count;
        enter_key(8); // pending edit, so a stray commit would show
        drive_keys(num_keys'(1) << 4, debounce_cycles / 2);
        drive_keys('0, hold_cycles);
        drive_keys(num_keys'(1) << key_star, debounce_cycles / 2);
        drive_keys('0, hold_cycles);
        drive_keys((num_keys'(1) << 0) | (num_keys'(1) << key_star), hold_cycles);
        drive_keys('0, hold_cycles);
        enter_key(key_star); // only the pending digit may change
        finish_test("glitch and double press", errors_before);

        errors_before = error_count;
        for (int i = 0; i < 40; i++) begin
            rng_state = xorshift32(rng_state);
            code      = int'(rng_state % 32'(num_keys));
            enter_key(code);
            if (i % 5 == 4)
                enter_key(key_star);
        end
        wait_cycles(settle_cycles);
        finish_test("random presses", errors_before);

        $display("tests passed %0d, failed %0d, assertion errors %0d",
                 tests_passed, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: compile.f
source/keypad_pkg.sv
source/segment_pkg.sv
source/keypad_scan.sv
source/digit_entry.sv
source/digit_register_file.sv
source/segment_mux.sv
source/keypad_display_top.sv
dv/keypad_display_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= keypad_display_tb
FILELIST  ?= compile.f

SIM := obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
